// File: tb.f
rtl/cfg_pkg.sv
rtl/io_pkg.sv
rtl/sys_cfg_if.sv
rtl/boot_ctrl.sv
rtl/input_mapper.sv
rtl/audio_volume.sv
rtl/ram_scrambler.sv
rtl/disk_arbiter.sv
rtl/st_glue_top.sv
verif/tb_clkgen.sv
verif/st_glue_sva.sv
verif/st_glue_tb.sv

// File: Makefile
# Verilator build and run of the glue testbench

TOP := st_glue_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 --top-module $(TOP) -f tb.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir

// File: verif/st_glue_tb.sv
/*
  testbench of the glue top level
  random stimulus on all inputs, a cycle model that predicts
  every output at the falling edge, boot timing phases
*/
`default_nettype none

module st_glue_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cfg_pkg::*;
  import io_pkg::*;

  localparam logic [31:0] BOOT_TIMEOUT = 32'd300;  // short wait in simulation
  localparam int MODE_CYCLES = 60;                  // per mouse source and volume pair
  localparam int RUN_CYCLES  = 16 * MODE_CYCLES + 2 * (int'(BOOT_TIMEOUT) + 40);

  logic        clk32;
  logic        por_rst;
  logic        soft_rst;  // reset for the boot phases
  logic        rst;
  mouse_src_t  mouse_src;
  volume_t     volume;
  logic        coldboot;
  logic        warm_reset;
  img_size_t   img_size;
  logic        reset_button;
  logic        ram_ready;
  logic        flash_ready;
  db9_t        db9;
  joy_t        hid_mouse;
  hid_joy_t    hid_joy;
  kbd_matrix_t kbd_matrix;
  kbd_cols_t   kbd_cols;
  joy_t        joy0;
  joy_t        joy1;
  kbd_row_t    kbd_row;
  raw_sample_t audio_in_l;
  raw_sample_t audio_in_r;
  sample_t     audio_out_l;
  sample_t     audio_out_r;
  ram_addr_t   ram_addr_in;
  ram_addr_t   ram_addr_out;
  req_t        fdc_rd;
  req_t        fdc_wr;
  lba_t        fdc_lba;
  sd_byte_t    fdc_wr_byte;
  req_t        acsi_rd;
  req_t        acsi_wr;
  lba_t        acsi_lba;
  sd_byte_t    acsi_wr_byte;
  logic [3:0]  sd_rstart;
  logic [3:0]  sd_wstart;
  lba_t        sd_lba;
  sd_byte_t    sd_wr_byte;
  logic        sd_ready;
  logic        core_reset_n;

  // model state, what the registers should hold after the last edge
  sample_t     exp_l = '0;
  sample_t     exp_r = '0;
  logic [1:0]  scr_cnt = 2'd0;  // coldboot edges mod 4
  logic        cb_last = 1'b0;
  logic        owner_m = 1'b0;  // hard disk asked last
  logic        sd_m = 1'b0;
  logic        core_m = 1'b0;
  logic [31:0] wait_m = '0;

  int err_input = 0;
  int err_audio = 0;
  int err_ram = 0;
  int err_disk = 0;
  int err_boot = 0;

  tb_clkgen #(.RST_CYCLES(3)) clkgen (.clk32, .rst(por_rst));
  assign rst = por_rst | soft_rst;

  st_glue_top #(.BOOT_TIMEOUT(BOOT_TIMEOUT)) uut (.*);

  // pins low active, fire2 fire1 up down left right
  function automatic joy_t db9_layout(input db9_t p, input logic amiga);
    joy_t j;
    j[5] = !p[5];
    j[4] = !p[0];
    j[3] = amiga ? !p[3] : !p[2];  // up
    j[2] = !p[1];
    j[1] = !p[4];
    j[0] = amiga ? !p[2] : !p[3];  // right
    return j;
  endfunction

  function automatic kbd_row_t row_model(input kbd_matrix_t m, input kbd_cols_t c);
    kbd_row_t r;
    r = 8'hff;
    for (int i = 0; i < 15; i++)
      if (c[i] == 1'b0)
        r = r & m[i];
    return r;
  endfunction

  function automatic sample_t volume_model(input raw_sample_t s, input volume_t v);
    sample_t x;
    x = sample_t'(s);  // signed cast widens with the sign
    case (v)
      VOL_MUTE:    return '0;
      VOL_QUARTER: return x >>> 2;
      VOL_HALF:    return x >>> 1;
      default:     return x;
    endcase
  endfunction

  task automatic check_joy(input string name, input joy_t exp, input joy_t act);
    if (act !== exp) begin
      err_input++;
      $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_row(input string name, input kbd_row_t exp, input kbd_row_t act);
    if (act !== exp) begin
      err_input++;
      $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      err_audio++;
      $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_addr(input string name, input ram_addr_t exp, input ram_addr_t act);
    if (act !== exp) begin
      err_ram++;
      $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_lba(input string name, input lba_t exp, input lba_t act);
    if (act !== exp) begin
      err_disk++;
      $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_byte(input string name, input sd_byte_t exp, input sd_byte_t act);
    if (act !== exp) begin
      err_disk++;
      $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_start(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      err_disk++;
      $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_boot++;
      $display("ERR %s expected %b actual %b at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      err_boot++;
      $display("ERR %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  function automatic raw_sample_t pick_sample();
    case ($urandom % 8)
      0:       return 15'h4000;  // most negative
      1:       return 15'h3fff;
      default: return raw_sample_t'($urandom);
    endcase
  endfunction

  function automatic req_t sparse_req();
    return ($urandom % 3 == 0) ? req_t'($urandom) : req_t'(0);
  endfunction

  // called right after a rising edge
  task automatic drive_random();
    kbd_matrix_t m;
    for (int i = 0; i < 15; i++)
      m[i] = kbd_row_t'($urandom);
    kbd_matrix <= m;
    case ($urandom % 4)
      0:       kbd_cols <= '1;  // nothing selected
      1:       kbd_cols <= ~(kbd_cols_t'(1) << ($urandom % 15));
      default: kbd_cols <= kbd_cols_t'($urandom);
    endcase
    db9          <= db9_t'($urandom);
    hid_mouse    <= joy_t'($urandom);
    hid_joy      <= hid_joy_t'($urandom);
    audio_in_l   <= pick_sample();
    audio_in_r   <= pick_sample();
    ram_addr_in  <= ram_addr_t'($urandom);
    coldboot     <= ($urandom % 3 == 0) ? !coldboot : coldboot;
    fdc_rd       <= sparse_req();
    fdc_wr       <= sparse_req();
    acsi_rd      <= sparse_req();
    acsi_wr      <= sparse_req();
    fdc_lba      <= lba_t'($urandom);
    acsi_lba     <= lba_t'($urandom);
    fdc_wr_byte  <= sd_byte_t'($urandom);
    acsi_wr_byte <= sd_byte_t'($urandom);
    warm_reset   <= ($urandom % 8 == 0);  // mostly let the machine run
    reset_button <= ($urandom % 8 == 0);
    ram_ready    <= ($urandom % 8 != 0);
    flash_ready  <= ($urandom % 8 != 0);
  endtask

  // check what the last edge left, then step the model over the next one
  always @(negedge clk32) begin : model
    joy_t atari;
    joy_t exp0;
    logic fdc_req;
    logic acsi_req;
    logic owner;

    atari = db9_layout(db9, 1'b0);
    case (mouse_src)
      MOUSE_HOST:      exp0 = hid_mouse;
      MOUSE_DB9_ATARI: exp0 = atari;
      MOUSE_DB9_AMIGA: exp0 = db9_layout(db9, 1'b1);
      default:         exp0 = '0;
    endcase
    check_joy("joy0", exp0, joy0);
    check_joy("joy1", {1'b0, hid_joy[4:0] | (mouse_src == MOUSE_HOST ? atari[4:0] : 5'd0)},
              joy1);
    check_row("kbd_row", row_model(kbd_matrix, kbd_cols), kbd_row);

    check_sample("audio_l", exp_l, audio_out_l);
    check_sample("audio_r", exp_r, audio_out_r);
    exp_l = rst ? sample_t'(0) : volume_model(audio_in_l, volume);
    exp_r = rst ? sample_t'(0) : volume_model(audio_in_r, volume);

    check_addr("ram_addr", ram_addr_in ^ (ram_addr_t'(scr_cnt) << 2), ram_addr_out);
    if (rst) begin
      scr_cnt = 2'd0;
      cb_last = 1'b0;
    end else begin
      if (coldboot && !cb_last)
        scr_cnt = scr_cnt + 2'd1;
      cb_last = coldboot;
    end

    fdc_req  = |{fdc_rd, fdc_wr};
    acsi_req = |{acsi_rd, acsi_wr};
    owner    = acsi_req || owner_m;  // hard disk side owns the card
    check_start("sd_rstart", {acsi_rd, fdc_rd}, sd_rstart);
    check_start("sd_wstart", {acsi_wr, fdc_wr}, sd_wstart);
    check_lba("sd_lba", owner ? acsi_lba : fdc_lba, sd_lba);
    check_byte("sd_wr_byte", owner ? acsi_wr_byte : fdc_wr_byte, sd_wr_byte);
    if (rst || fdc_req)
      owner_m = 1'b0;  // floppy wins a tie
    else if (acsi_req)
      owner_m = 1'b1;

    check_bit("sd_ready", sd_m, sd_ready);
    check_bit("core_reset_n", core_m, core_reset_n);
    if (rst) begin
      sd_m   = 1'b0;
      core_m = 1'b0;
      wait_m = '0;
    end else begin
      core_m = !warm_reset && !reset_button && ram_ready && flash_ready && sd_m;
      if (!sd_m) begin
        if (img_size != '0 || wait_m == BOOT_TIMEOUT)
          sd_m = 1'b1;
        else
          wait_m = wait_m + 32'd1;
      end
    end
  end

  // reset with no image, the card becomes ready by timeout only
  task automatic boot_timeout_phase();
    int cycles;
    @(posedge clk32);
    soft_rst     <= 1'b1;
    img_size     <= '0;
    warm_reset   <= 1'b0;
    reset_button <= 1'b0;
    ram_ready    <= 1'b1;
    flash_ready  <= 1'b1;
    repeat (3) @(posedge clk32);
    soft_rst <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk32);
      cycles++;
    end while (!sd_ready && cycles < int'(BOOT_TIMEOUT) + 10);
    // one edge still in reset, BOOT_TIMEOUT counts, one edge to switch
    check_count("boot timeout", int'(BOOT_TIMEOUT) + 2, cycles);
  endtask

  task automatic boot_image_phase();
    int cycles;
    @(posedge clk32);
    soft_rst <= 1'b1;
    img_size <= $urandom | 32'd1;  // any mounted image
    repeat (3) @(posedge clk32);
    soft_rst <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk32);
      cycles++;
    end while (!sd_ready && cycles < 4);
    if (!sd_ready || cycles > 2) begin
      err_boot++;
      $display("sd_ready did not rise within two cycles of a mounted image");
    end
    repeat (30) begin
      @(posedge clk32);
      drive_random();
    end
  endtask

  initial begin
    int total;
    void'($urandom(5688));
    soft_rst     <= 1'b0;
    mouse_src    <= MOUSE_HOST;
    volume       <= VOL_FULL;
    coldboot     <= 1'b0;
    warm_reset   <= 1'b0;
    img_size     <= '0;
    reset_button <= 1'b0;
    ram_ready    <= 1'b1;
    flash_ready  <= 1'b1;
    db9          <= '1;
    hid_mouse    <= '0;
    hid_joy      <= '0;
    kbd_matrix   <= '1;
    kbd_cols     <= '1;
    audio_in_l   <= '0;
    audio_in_r   <= '0;
    ram_addr_in  <= '0;
    fdc_rd       <= '0;
    fdc_wr       <= '0;
    fdc_lba      <= '0;
    fdc_wr_byte  <= '0;
    acsi_rd      <= '0;
    acsi_wr      <= '0;
    acsi_lba     <= '0;
    acsi_wr_byte <= '0;
    wait (por_rst == 1'b0);

    // every mouse source against every volume code
    for (int m = 0; m < 4; m++) begin
      for (int v = 0; v < 4; v++) begin
        @(posedge clk32);
        mouse_src <= mouse_src_t'(m);
        volume    <= volume_t'(v);
        drive_random();
        repeat (MODE_CYCLES - 1) begin
          @(posedge clk32);
          drive_random();
        end
      end
    end

    boot_timeout_phase();
    boot_image_phase();
    repeat (2) @(posedge clk32);  // last falling edge checks done

    total = err_input + err_audio + err_ram + err_disk + err_boot
            + int'(uut.u_disk.sva_disk.fail_cnt) + int'(uut.u_boot.sva_boot.fail_cnt);
    $display("errors input %0d audio %0d ram %0d disk %0d boot %0d assertions %0d",
             err_input, err_audio, err_ram, err_disk, err_boot,
             uut.u_disk.sva_disk.fail_cnt + uut.u_boot.sva_boot.fail_cnt);
    if (total == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // all phases plus a margin
  initial begin
    repeat (RUN_CYCLES + 1000) @(posedge clk32);
    $display("watchdog expired, the run did not reach its end");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/st_glue_sva.sv
/*
  assertions bound into the disk arbiter and the boot controller
  owner flag after reset, machine reset against warm reset
  and sd_ready holding once it is set
*/
`default_nettype none

module st_glue_sva (
  input logic clk32,
  input logic rst,
  input logic owner_flag,
  input logic warm_reset,
  input logic sd_ready,
  input logic core_reset_n
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // failed assertions so far

  // reset hands the card to the floppy
  a_owner_clear: assert property (@(posedge clk32) rst |=> !owner_flag)
    else begin
      fail_cnt++;
      $error("owner flag set after reset");
    end

  // warm reset one cycle back keeps the machine in reset
  a_core_warm: assert property (@(posedge clk32) disable iff (rst)
    $past(warm_reset) |-> !core_reset_n)
    else begin
      fail_cnt++;
      $error("core_reset_n high after warm_reset");
    end

  a_sd_hold: assert property (@(posedge clk32) sd_ready && !rst |=> sd_ready)
    else begin
      fail_cnt++;
      $error("sd_ready dropped without reset");
    end

endmodule

// unused inputs of each copy are tied low
bind disk_arbiter st_glue_sva sva_disk (
  .clk32, .rst, .owner_flag(acsi_owner_d),
  .warm_reset(1'b0), .sd_ready(1'b0), .core_reset_n(1'b0)
);

bind boot_ctrl st_glue_sva sva_boot (
  .clk32, .rst, .owner_flag(1'b0),
  .warm_reset(cfg.warm_reset), .sd_ready, .core_reset_n
);

`default_nettype wire

// File: verif/tb_clkgen.sv
/*
  clock and power-on reset for the testbench
  10 ns clock, reset held for a few edges
*/
`default_nettype none

module tb_clkgen #(
  parameter int RST_CYCLES = 3
) (
  output logic clk32,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk32 = 1'b0;
    forever #5 clk32 = ~clk32;  // 10 ns period
  end

  initial begin
    rst <= 1'b1;
    repeat (RST_CYCLES) @(posedge clk32);
    rst <= 1'b0;  // released on an edge
  end

endmodule

`default_nettype wire

// File: rtl/st_glue_top.sv
/*
  glue top level
  plain ports in, configuration levels bundled for the
  boot, input, audio, scrambler and disk blocks
*/
`default_nettype none

module st_glue_top #(
  parameter logic [31:0] BOOT_TIMEOUT = 32'd64000000
) (
  input  logic                 clk32,
  input  logic                 rst,
  // user configuration
  input  cfg_pkg::mouse_src_t  mouse_src,
  input  cfg_pkg::volume_t     volume,
  input  logic                 coldboot,
  input  logic                 warm_reset,
  input  cfg_pkg::img_size_t   img_size,
  input  logic                 reset_button,
  input  logic                 ram_ready,
  input  logic                 flash_ready,
  // controllers and keyboard
  input  io_pkg::db9_t         db9,
  input  io_pkg::joy_t         hid_mouse,
  input  io_pkg::hid_joy_t     hid_joy,
  input  io_pkg::kbd_matrix_t  kbd_matrix,
  input  io_pkg::kbd_cols_t    kbd_cols,
  output io_pkg::joy_t         joy0,
  output io_pkg::joy_t         joy1,
  output io_pkg::kbd_row_t     kbd_row,
  // audio
  input  io_pkg::raw_sample_t  audio_in_l,
  input  io_pkg::raw_sample_t  audio_in_r,
  output io_pkg::sample_t      audio_out_l,
  output io_pkg::sample_t      audio_out_r,
  // ram
  input  io_pkg::ram_addr_t    ram_addr_in,
  output io_pkg::ram_addr_t    ram_addr_out,
  // sd card requests
  input  io_pkg::req_t         fdc_rd,
  input  io_pkg::req_t         fdc_wr,
  input  io_pkg::lba_t         fdc_lba,
  input  io_pkg::sd_byte_t     fdc_wr_byte,
  input  io_pkg::req_t         acsi_rd,
  input  io_pkg::req_t         acsi_wr,
  input  io_pkg::lba_t         acsi_lba,
  input  io_pkg::sd_byte_t     acsi_wr_byte,
  output logic [3:0]           sd_rstart,
  output logic [3:0]           sd_wstart,
  output io_pkg::lba_t         sd_lba,
  output io_pkg::sd_byte_t     sd_wr_byte,
  // boot
  output logic                 sd_ready,
  output logic                 core_reset_n
);

  sys_cfg_if cfg ();

  assign cfg.mouse_src  = mouse_src;
  assign cfg.volume     = volume;
  assign cfg.coldboot   = coldboot;
  assign cfg.warm_reset = warm_reset;

  boot_ctrl #(.BOOT_TIMEOUT(BOOT_TIMEOUT)) u_boot (
    .clk32, .rst, .cfg(cfg.boot), .img_size,
    .reset_button, .ram_ready, .flash_ready,
    .sd_ready, .core_reset_n
  );

  input_mapper u_inputs (
    .cfg(cfg.inputs), .db9, .hid_mouse, .hid_joy,
    .kbd_matrix, .kbd_cols, .joy0, .joy1, .kbd_row
  );

  audio_volume u_audio (
    .clk32, .rst, .cfg(cfg.audio),
    .in_l(audio_in_l), .in_r(audio_in_r),
    .out_l(audio_out_l), .out_r(audio_out_r)
  );

  ram_scrambler u_scram (
    .clk32, .rst, .cfg(cfg.scram), .ram_addr_in, .ram_addr_out
  );

  disk_arbiter u_disk (
    .clk32, .rst,
    .fdc_rd, .fdc_wr, .fdc_lba, .fdc_wr_byte,
    .acsi_rd, .acsi_wr, .acsi_lba, .acsi_wr_byte,
    .sd_rstart, .sd_wstart, .sd_lba, .sd_wr_byte
  );

endmodule

`default_nettype wire

// File: rtl/disk_arbiter.sv
/*
  disk arbiter
  floppy and hard disk share one sd card port, the last
  requester keeps the sector number and write byte
*/
`default_nettype none

module disk_arbiter (
  input  logic             clk32,
  input  logic             rst,
  input  io_pkg::req_t     fdc_rd,
  input  io_pkg::req_t     fdc_wr,
  input  io_pkg::lba_t     fdc_lba,
  input  io_pkg::sd_byte_t fdc_wr_byte,
  input  io_pkg::req_t     acsi_rd,
  input  io_pkg::req_t     acsi_wr,
  input  io_pkg::lba_t     acsi_lba,
  input  io_pkg::sd_byte_t acsi_wr_byte,
  output logic [3:0]       sd_rstart,
  output logic [3:0]       sd_wstart,
  output io_pkg::lba_t     sd_lba,
  output io_pkg::sd_byte_t sd_wr_byte
);
  logic fdc_req;
  logic acsi_req;
  logic acsi_owner_d;  // sticky, hard disk asked last
  logic acsi_owner;

  assign fdc_req  = (fdc_rd != '0) || (fdc_wr != '0);
  assign acsi_req = (acsi_rd != '0) || (acsi_wr != '0);

  always_ff @(posedge clk32) begin
    if (rst)
      acsi_owner_d <= 1'b0;
    else if (fdc_req)
      acsi_owner_d <= 1'b0;  // floppy wins a tie
    else if (acsi_req)
      acsi_owner_d <= 1'b1;
  end

  assign acsi_owner = acsi_req || acsi_owner_d;

  // hard disk drives in the upper half
  assign sd_rstart  = {acsi_rd, fdc_rd};
  assign sd_wstart  = {acsi_wr, fdc_wr};
  assign sd_lba     = acsi_owner ? acsi_lba : fdc_lba;
  assign sd_wr_byte = acsi_owner ? acsi_wr_byte : fdc_wr_byte;

endmodule

`default_nettype wire

// File: rtl/ram_scrambler.sv
/*
  ram scrambler
  each coldboot request bumps a 2 bit value that is xored into
  the word address, so old ram contents look lost
*/
`default_nettype none

module ram_scrambler (
  input  logic              clk32,
  input  logic              rst,
  sys_cfg_if.scram          cfg,
  input  io_pkg::ram_addr_t ram_addr_in,
  output io_pkg::ram_addr_t ram_addr_out
);
  logic       coldboot_d;  // previous cycle
  logic [1:0] scramble;

  always_ff @(posedge clk32) begin
    if (rst) begin
      coldboot_d <= 1'b0;
      scramble   <= 2'd0;
    end else begin
      coldboot_d <= cfg.coldboot;
      if (cfg.coldboot && !coldboot_d)
        scramble <= scramble + 2'd1;  // rising edge only
    end
  end

  // word bits 3 and 2 get flipped
  assign ram_addr_out = {ram_addr_in[21:4], ram_addr_in[3:2] ^ scramble, ram_addr_in[1:0]};

endmodule

`default_nettype wire

// File: rtl/audio_volume.sv
/*
  audio volume
  widens both 15 bit channels to 16 bits and scales them
  by the four step volume, registered
*/
`default_nettype none

module audio_volume (
  input  logic                clk32,
  input  logic                rst,
  sys_cfg_if.audio            cfg,
  input  io_pkg::raw_sample_t in_l,
  input  io_pkg::raw_sample_t in_r,
  output io_pkg::sample_t     out_l,
  output io_pkg::sample_t     out_r
);
  import cfg_pkg::*;
  import io_pkg::*;

  // signed division by shifting
  function automatic sample_t scale(input raw_sample_t s, input volume_t v);
    sample_t ext;
    ext = {s[14], s};  // sign extend
    case (v)
      VOL_MUTE:    return '0;
      VOL_QUARTER: return ext >>> 2;
      VOL_HALF:    return ext >>> 1;
      VOL_FULL:    return ext;
      default:     return ext;
    endcase
  endfunction

  always_ff @(posedge clk32) begin
    if (rst) begin
      out_l <= '0;
      out_r <= '0;
    end else begin
      out_l <= scale(in_l, cfg.volume);
      out_r <= scale(in_r, cfg.volume);
    end
  end

endmodule

`default_nettype wire

// File: rtl/input_mapper.sv
/*
  input mapper
  DB9 port decoding, mouse/joystick merging onto the two
  controller ports and keyboard matrix row reduction
*/
`default_nettype none

module input_mapper (
  sys_cfg_if.inputs           cfg,
  input  io_pkg::db9_t        db9,
  input  io_pkg::joy_t        hid_mouse,
  input  io_pkg::hid_joy_t    hid_joy,
  input  io_pkg::kbd_matrix_t kbd_matrix,
  input  io_pkg::kbd_cols_t   kbd_cols,
  output io_pkg::joy_t        joy0,
  output io_pkg::joy_t        joy1,
  output io_pkg::kbd_row_t    kbd_row
);
  import cfg_pkg::*;
  import io_pkg::*;

  joy_t       db9_atari;
  joy_t       db9_amiga;
  logic [4:0] db9_joy;  // db9 share of joy1

  // pins are active low, reorder into fire2..right
  assign db9_atari = ~{db9[5], db9[0], db9[2], db9[1], db9[4], db9[3]};
  assign db9_amiga = ~{db9[5], db9[0], db9[3], db9[1], db9[4], db9[2]};

  // a db9 mouse replaces the host mouse, mice hold lines active
  always_comb begin
    case (cfg.mouse_src)
      MOUSE_HOST:      joy0 = hid_mouse;
      MOUSE_DB9_ATARI: joy0 = db9_atari;
      MOUSE_DB9_AMIGA: joy0 = db9_amiga;
      MOUSE_NONE:      joy0 = '0;
      default:         joy0 = '0;
    endcase
  end

  // db9 acts as joystick only while the mouse comes from the host
  assign db9_joy = (cfg.mouse_src == MOUSE_HOST) ? db9_atari[4:0] : 5'b0;
  assign joy1    = {1'b0, hid_joy[4:0] | db9_joy};  // wired-or, no fire2

  // and of all selected rows, idle row reads all ones
  always_comb begin
    kbd_row = '1;
    for (int i = 0; i < 15; i++) begin
      if (!kbd_cols[i])
        kbd_row &= kbd_matrix[i];
    end
  end

endmodule

`default_nettype wire

// File: rtl/boot_ctrl.sv
/*
  boot controller
  waits for a mounted sd image or a timeout, then releases the
  machine reset once every ready and reset condition agrees
*/
`default_nettype none

module boot_ctrl #(
  parameter logic [31:0] BOOT_TIMEOUT = 32'd64000000  // 2 s at 32 MHz
) (
  input  logic              clk32,
  input  logic              rst,
  sys_cfg_if.boot           cfg,
  input  cfg_pkg::img_size_t img_size,
  input  logic              reset_button,
  input  logic              ram_ready,
  input  logic              flash_ready,
  output logic              sd_ready,
  output logic              core_reset_n
);
  import cfg_pkg::*;

  boot_state_t state;
  logic [31:0] wait_cnt;  // cycles spent waiting for the image

  // give the host time to mount a default image
  always_ff @(posedge clk32) begin
    if (rst) begin
      state    <= boot_wait;
      wait_cnt <= '0;
    end else begin
      case (state)
        boot_wait: begin
          if (img_size != '0 || wait_cnt == BOOT_TIMEOUT)
            state <= boot_run;  // image seen or gave up waiting
          else
            wait_cnt <= wait_cnt + 32'd1;
        end
        boot_run: state <= boot_run;  // stays until next reset
        default:  state <= boot_wait;
      endcase
    end
  end

  assign sd_ready = (state == boot_run);

  // machine runs only when nothing holds it back
  always_ff @(posedge clk32) begin
    if (rst)
      core_reset_n <= 1'b0;
    else
      core_reset_n <= !cfg.warm_reset && !reset_button &&
                      ram_ready && flash_ready && sd_ready;
  end

endmodule

`default_nettype wire

// File: rtl/sys_cfg_if.sv
/*
  configuration bundle
  static user levels fanned out to the blocks that need them
*/
`default_nettype none

interface sys_cfg_if;
  import cfg_pkg::*;

  mouse_src_t mouse_src;
  volume_t    volume;
  logic       coldboot;    // rising edge = new ram scramble
  logic       warm_reset;  // holds the machine in reset

  modport boot   (input warm_reset);
  modport inputs (input mouse_src);
  modport audio  (input volume);
  modport scram  (input coldboot);

endinterface

`default_nettype wire

// File: rtl/io_pkg.sv
/*
  data types of the machine side i/o
  controller bits, keyboard matrix, audio samples, ram and disk words
*/
`default_nettype none

package io_pkg;

  typedef logic [5:0]  joy_t;        // fire2 fire1 up down left right, active high
  typedef logic [7:0]  hid_joy_t;    // host joystick, only low 5 bits used
  typedef logic [7:0]  db9_t;        // raw pins, active low

  typedef logic [7:0]  kbd_row_t;    // active low
  typedef logic [14:0] kbd_cols_t;   // column select, active low
  typedef kbd_row_t [14:0] kbd_matrix_t;

  typedef logic signed [14:0] raw_sample_t;
  typedef logic signed [15:0] sample_t;

  typedef logic [21:0] ram_addr_t;   // word address
  typedef logic [31:0] lba_t;
  typedef logic [7:0]  sd_byte_t;
  typedef logic [1:0]  req_t;        // one bit per drive

endpackage

`default_nettype wire

// File: rtl/cfg_pkg.sv
/*
  configuration types for the glue logic
  user settings that come from the OSD side, plus the boot FSM states
*/
`default_nettype none

package cfg_pkg;

  typedef logic [1:0]  mouse_src_t;  // where joy0 gets its mouse from
  typedef logic [1:0]  volume_t;     // four step output volume
  typedef logic [31:0] img_size_t;   // non-zero once an image is mounted

  // mouse source codes
  localparam mouse_src_t MOUSE_HOST      = 2'd0;
  localparam mouse_src_t MOUSE_DB9_ATARI = 2'd1;
  localparam mouse_src_t MOUSE_DB9_AMIGA = 2'd2;
  localparam mouse_src_t MOUSE_NONE      = 2'd3;

  // volume codes
  localparam volume_t VOL_MUTE    = 2'd0;
  localparam volume_t VOL_QUARTER = 2'd1;
  localparam volume_t VOL_HALF    = 2'd2;
  localparam volume_t VOL_FULL    = 2'd3;

  typedef enum logic {boot_wait, boot_run} boot_state_t;

endpackage

`default_nettype wire
